// ==== include/ethSwitch_settings.svh ====
// Switch-wide constants. Port 2 and port 3 MAC layout assumes exactly four ports
// Queue depths must be powers of two
`ifndef ETHSWITCH_SETTINGS_SVH
`define ETHSWITCH_SETTINGS_SVH

`define NumPorts        4                   // Switch ports
`define UplinkPorts     2                   // Ports 0 and 1 learn their host MAC
`define MaxFrameBytes   64                  // Largest frame after SFD
`define DataQueueDepth  128                 // Byte items per lane
`define InfoQueueDepth  4                   // Packets per lane
`define InterPacketGap  12                  // Idle cycles between transmitted packets
`define SfdByte         8'hD5
`define CompanyId       24'hFA610E          // Upper 24 bits of the local MACs
`define PsMacField      16'h0300            // Middle field of port 2 MAC
`define RtMacField      16'h1394            // Middle field of port 3 MAC
`define BroadcastMac    48'hFFFF_FFFF_FFFF
`endif

// ==== source/ethSwitchPkg.sv ====
// Types shared by the switch blocks
// Byte status encoding: 01 first, 10 last, 11 last of an errored frame
`include "ethSwitch_settings.svh"

package ethSwitchPkg;

  typedef logic [47:0] macAddrT;
  typedef logic [`NumPorts-1:0] portMaskT;   // One bit per output port
  typedef logic [1:0] portIdxT;

  typedef enum logic [1:0] {
    statNone  = 2'b00,
    statFirst = 2'b01,   // First destination byte
    statLast  = 2'b10,   // Final byte, clean frame
    statErr   = 2'b11    // Final byte, frame saw rxErr
  } byteStatT;

  // Queue item for frame bytes, 10 bits
  typedef struct packed {
    byteStatT   stat;
    logic [7:0] data;
  } byteItemT;

  // Queue item per packet, set when the frame was received with an error
  typedef logic infoItemT;

endpackage

// ==== source/rxFrameParser.sv ====
// Receive side of one port. Preamble is dropped up to SFD; frames need at least 12 bytes
// Output lags input by 7 cycles; srcMac is valid from the srcLearn pulse onward
`include "ethSwitch_settings.svh"
`timescale 1ns/100ps

module rxFrameParser import ethSwitchPkg::*; (
  input  logic       RxClk,
  input  logic       rstN,
  input  logic       rxValid,
  input  logic [7:0] rxD,
  input  logic       rxErr,
  output byteItemT   outItem,
  output logic       outValid,
  output macAddrT    destMac,
  output macAddrT    srcMac,
  output logic       srcLearn
);

  localparam int DelayLen = 7;

  typedef enum logic [1:0] {stIdle, stPreamble, stFrame} rxStateT;

  rxStateT rxState;
  logic frameByte;                          // Byte after SFD on the input
  logic [3:0] byteCnt;                      // Header byte index, saturates at 12
  logic [47:0] hdr;                         // Last six input bytes
  logic [DelayLen-1:0][7:0] dlyD;
  logic [DelayLen-1:0] dlyE;
  logic [DelayLen:0] dlyV;                  // One extra stage to spot the first byte
  logic isFirst, isLast, errAcc, frameErr;

  assign frameByte = rxValid & (rxState == stFrame);

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      rxState  <= stIdle;
      byteCnt  <= 4'd0;
      srcLearn <= 1'b0;
      dlyV     <= '0;
      frameErr <= 1'b0;
    end else begin
      srcLearn <= frameByte & (byteCnt == 4'd11);   // Sixth source byte
      dlyV     <= {dlyV[DelayLen-1:0], frameByte};
      if (dlyV[DelayLen-1])
        frameErr <= errAcc;
      if (frameByte && byteCnt != 4'd12)
        byteCnt <= byteCnt + 4'd1;
      case (rxState)
        stIdle, stPreamble: begin
          if (!rxValid) begin
            rxState <= stIdle;
          end else if (rxD == `SfdByte) begin
            rxState <= stFrame;                 // SFD itself is not kept
            byteCnt <= 4'd0;
          end else begin
            rxState <= stPreamble;
          end
        end
        default: begin
          if (!rxValid)
            rxState <= stIdle;
        end
      endcase
    end
  end

  // Delay line and header capture
  always_ff @(posedge RxClk) begin
    dlyD <= {dlyD[DelayLen-2:0], rxD};
    dlyE <= {dlyE[DelayLen-2:0], rxErr & frameByte};
    if (frameByte)
      hdr <= {hdr[39:0], rxD};
    if (dlyV[DelayLen-2] && !dlyV[DelayLen-1])
      destMac <= hdr;                         // All six dest bytes in, first byte leaves next
    if (frameByte && byteCnt == 4'd11)
      srcMac <= {hdr[39:0], rxD};
  end

  assign isFirst = dlyV[DelayLen-1] & ~dlyV[DelayLen];
  assign isLast  = dlyV[DelayLen-1] & ~dlyV[DelayLen-2];   // Look ahead one stage
  assign errAcc  = (frameErr & ~isFirst) | dlyE[DelayLen-1];

  assign outValid     = dlyV[DelayLen-1];
  assign outItem.data = dlyD[DelayLen-1];
  assign outItem.stat = isFirst ? statFirst :
                        isLast  ? (errAcc ? statErr : statLast) : statNone;

  // A frame too short to hold its header would collapse first and last
  assert property (@(posedge RxClk) disable iff (!rstN) !(isFirst && isLast));

endmodule

// ==== source/forwardDecision.sv ====
// Destination mask per input port. Assumes four ports: uplinks 0 and 1, local ports 2 and 3
// Uplinks keep the source MAC of the last frame they received
`include "ethSwitch_settings.svh"
`timescale 1ns/100ps

module forwardDecision import ethSwitchPkg::*; (
  input  logic                     RxClk,
  input  logic                     rstN,
  input  macAddrT [`NumPorts-1:0]  destMac,
  input  macAddrT [`NumPorts-1:0]  srcMac,
  input  logic [`NumPorts-1:0]     srcLearn,
  input  logic [`NumPorts-1:0]     portActive,
  input  logic [3:0]               boardId,
  output portMaskT [`NumPorts-1:0] fwdMask
);

  macAddrT [`UplinkPorts-1:0] hostMac;     // Learned host per uplink
  macAddrT psMac, rtMac;

  assign psMac = {`CompanyId, `PsMacField, 4'd0, boardId};
  assign rtMac = {`CompanyId, `RtMacField, 4'd0, boardId};

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      hostMac <= {`UplinkPorts{`BroadcastMac}};
    end else begin
      for (int u = 0; u < `UplinkPorts; u++) begin
        if (!portActive[u])
          hostMac[u] <= `BroadcastMac;      // Forget while link is down
        else if (srcLearn[u])
          hostMac[u] <= srcMac[u];
      end
    end
  end

  for (genvar i = 0; i < `NumPorts; i++) begin : genIn
    logic isBcast;
    logic [`NumPorts-1:0] hit;            // Exact match per output port

    assign isBcast = (destMac[i] == `BroadcastMac);
    assign hit = {destMac[i] == rtMac, destMac[i] == psMac,
                  destMac[i] == hostMac[1], destMac[i] == hostMac[0]};

    for (genvar o = 0; o < `NumPorts; o++) begin : genOut
      if (o == i) begin : genSelf
        assign fwdMask[i][o] = 1'b0;        // Never back out the receiving port
      end else begin : genOther
        // Unknown unicast floods to the uplinks only
        assign fwdMask[i][o] = portActive[o] &
                               (isBcast | hit[o] | ((o < `UplinkPorts) & ~|hit));
      end
    end
  end

endmodule

// ==== source/packetQueue.sv ====
// Synchronous FIFO, read data registered one cycle after rdEn
// Depth must be a power of two; flush empties it in one cycle
`timescale 1ns/100ps

module packetQueue #(
  parameter type ItemT = logic [7:0],
  parameter int  Depth = 16
) (
  input  logic                       RxClk,
  input  logic                       rstN,
  input  logic                       flush,
  input  logic                       wrValid,
  input  ItemT                       wrItem,
  input  logic                       rdEn,
  output ItemT                       rdItem,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(Depth+1)-1:0] freeCount
);

  localparam int AddrW = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  ItemT mem [Depth];
  logic [AddrW-1:0] wrPtr, rdPtr;
  logic [CntW-1:0] count;                  // Items held
  logic doWr, doRd;

  assign doWr = wrValid & ~full;
  assign doRd = rdEn & ~empty;

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWr)
        wrPtr <= wrPtr + 1'b1;              // Wraps at Depth
      if (doRd)
        rdPtr <= rdPtr + 1'b1;
      count <= count + CntW'(doWr) - CntW'(doRd);
    end
  end

  always_ff @(posedge RxClk) begin
    if (doWr)
      mem[wrPtr] <= wrItem;
    if (doRd)
      rdItem <= mem[rdPtr];
  end

  assign full      = (count == CntW'(Depth));
  assign empty     = (count == '0);
  assign freeCount = CntW'(Depth) - count;

  // Writers and readers are expected to look at the flags first
  assert property (@(posedge RxClk) disable iff (!rstN) !(wrValid && full));
  assert property (@(posedge RxClk) disable iff (!rstN) !(rdEn && empty));

endmodule

// ==== source/switchLane.sv ====
// One input-to-output path. A packet is taken whole or dropped at its first byte
// Frames longer than MaxFrameBytes are not supported
`include "ethSwitch_settings.svh"
`timescale 1ns/100ps

module switchLane import ethSwitchPkg::*; (
  input  logic     RxClk,
  input  logic     rstN,
  input  byteItemT inItem,
  input  logic     inValid,
  input  logic     fwdBit,                 // Forward decision, sampled at the first byte
  input  logic     outActive,
  input  logic     rdEn,
  input  logic     infoPop,
  output byteItemT rdItem,
  output logic     pktReady,
  output infoItemT pktErr
);

  logic isFirst, isEnd, roomOk, accepting, acceptNow;
  logic dataWr, infoWr, infoFull, infoEmpty;
  logic [$clog2(`DataQueueDepth+1)-1:0] dataFree;
  infoItemT infoIn;

  assign isFirst = inValid & (inItem.stat == statFirst);
  assign isEnd   = inValid & (inItem.stat == statLast || inItem.stat == statErr);
  assign roomOk  = (dataFree >= `MaxFrameBytes) & ~infoFull;   // Room for a whole frame

  // Accept decision is made on the first byte and held to the end
  assign acceptNow = outActive & (isFirst ? (fwdBit & roomOk) : accepting);
  assign dataWr    = inValid & acceptNow;
  assign infoWr    = isEnd & acceptNow;
  assign infoIn    = (inItem.stat == statErr);   // Error mark rides on the final byte

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN)
      accepting <= 1'b0;
    else if (!outActive || isEnd)
      accepting <= 1'b0;
    else if (isFirst)
      accepting <= fwdBit & roomOk;
  end

  packetQueue #(.ItemT(byteItemT), .Depth(`DataQueueDepth)) dataQ (
    .RxClk, .rstN,
    .flush(~outActive), .wrValid(dataWr), .wrItem(inItem), .rdEn,
    .rdItem, .full(), .empty(), .freeCount(dataFree)
  );

  packetQueue #(.ItemT(infoItemT), .Depth(`InfoQueueDepth)) infoQ (
    .RxClk, .rstN,
    .flush(~outActive), .wrValid(infoWr), .wrItem(infoIn), .rdEn(infoPop),
    .rdItem(pktErr), .full(infoFull), .empty(infoEmpty), .freeCount()
  );

  assign pktReady = ~infoEmpty;            // Whole packet stored

endmodule

// ==== source/txScheduler.sv ====
// Round-robin transmit of whole packets for one output port over its three lanes
// The info item is popped at grant so its error flag is ready by the last byte
// An output port must not go inactive while a packet is being sent
`include "ethSwitch_settings.svh"
`timescale 1ns/100ps

module txScheduler import ethSwitchPkg::*; (
  input  logic                         RxClk,
  input  logic                         rstN,
  input  logic [`NumPorts-2:0]         pktReady,
  input  byteItemT [`NumPorts-2:0]     laneItem,
  input  infoItemT [`NumPorts-2:0]     pktErr,
  input  logic                         txReady,
  output logic [`NumPorts-2:0]         rdEn,
  output logic [`NumPorts-2:0]         infoPop,
  output logic                         txEn,
  output logic [7:0]                   txD,
  output logic                         txErr
);

  localparam int NumLanes = `NumPorts - 1;
  localparam int GapW     = $clog2(`InterPacketGap + 1);

  logic [NumLanes-1:0] grant;              // One-hot while a packet is active
  portIdxT curLane, nxtLane;               // Last served and next candidate
  logic found, busy, startNow, endNow;
  logic [GapW-1:0] gapCnt;
  byteItemT curItem;

  assign busy     = |grant;
  assign curItem  = laneItem[curLane];
  assign endNow   = txEn & (curItem.stat == statLast || curItem.stat == statErr);
  assign startNow = ~busy & (gapCnt == '0) & found;

  // Search starts after the last served lane
  always_comb begin
    nxtLane = curLane;
    found   = 1'b0;
    for (int k = NumLanes; k >= 1; k--) begin
      if (pktReady[(int'(curLane) + k) % NumLanes]) begin
        nxtLane = portIdxT'((int'(curLane) + k) % NumLanes);
        found   = 1'b1;
      end
    end
  end

  always_comb begin
    rdEn    = '0;
    infoPop = '0;
    if (busy && txReady && !endNow)
      rdEn = grant;                        // Stop once the last byte shows up
    if (startNow)
      infoPop[nxtLane] = 1'b1;
  end

  always_ff @(posedge RxClk or negedge rstN) begin
    if (!rstN) begin
      grant   <= '0;
      curLane <= portIdxT'(NumLanes - 1);   // First pick goes to lane 0
      gapCnt  <= '0;
      txEn    <= 1'b0;
    end else begin
      txEn <= |rdEn;                        // Data arrives one cycle after pop
      if (startNow) begin
        grant   <= NumLanes'(1) << nxtLane;
        curLane <= nxtLane;
      end else if (endNow) begin
        grant  <= '0;
        gapCnt <= GapW'(`InterPacketGap);
      end else if (gapCnt != '0) begin
        gapCnt <= gapCnt - 1'b1;
      end
    end
  end

  // Output stage fed from the lane's registered read data
  assign txD   = txEn ? curItem.data : 8'h00;
  assign txErr = endNow & pktErr[curLane];

  assert property (@(posedge RxClk) disable iff (!rstN) $onehot0(grant));

endmodule

// ==== source/ethSwitch.sv ====
// Four-port store-and-forward switch on a single clock
// Lane slots at each output are ordered by input port, skipping the output itself
`include "ethSwitch_settings.svh"
`timescale 1ns/100ps

module ethSwitch import ethSwitchPkg::*; (
  input  logic                       RxClk,
  input  logic                       rstN,
  input  logic [`NumPorts-1:0]       rxValid,
  input  logic [`NumPorts-1:0][7:0]  rxD,
  input  logic [`NumPorts-1:0]       rxErr,
  input  logic [`NumPorts-1:0]       txReady,
  input  logic [`NumPorts-1:0]       portActive,
  input  logic [3:0]                 boardId,
  output logic [`NumPorts-1:0]       txEn,
  output logic [`NumPorts-1:0][7:0]  txD,
  output logic [`NumPorts-1:0]       txErr
);

  localparam int NumLanes = `NumPorts - 1;

  byteItemT [`NumPorts-1:0] parsedItem;
  logic [`NumPorts-1:0] parsedValid, srcLearn;
  macAddrT [`NumPorts-1:0] destMac, srcMac;
  portMaskT [`NumPorts-1:0] fwdMask;       // [in][out]

  // Lane signals grouped by output port, then slot
  byteItemT [`NumPorts-1:0][NumLanes-1:0] laneItem;
  infoItemT [`NumPorts-1:0][NumLanes-1:0] laneErr;
  logic [`NumPorts-1:0][NumLanes-1:0] laneReady, laneRdEn, laneInfoPop;

  for (genvar p = 0; p < `NumPorts; p++) begin : genPort
    rxFrameParser parser (
      .RxClk, .rstN,
      .rxValid(rxValid[p]), .rxD(rxD[p]), .rxErr(rxErr[p]),
      .outItem(parsedItem[p]), .outValid(parsedValid[p]),
      .destMac(destMac[p]), .srcMac(srcMac[p]), .srcLearn(srcLearn[p])
    );

    txScheduler sched (
      .RxClk, .rstN,
      .pktReady(laneReady[p]), .laneItem(laneItem[p]), .pktErr(laneErr[p]),
      .txReady(txReady[p]), .rdEn(laneRdEn[p]), .infoPop(laneInfoPop[p]),
      .txEn(txEn[p]), .txD(txD[p]), .txErr(txErr[p])
    );
  end

  forwardDecision fwd (
    .RxClk, .rstN, .destMac, .srcMac, .srcLearn, .portActive, .boardId, .fwdMask
  );

  for (genvar i = 0; i < `NumPorts; i++) begin : genIn
    for (genvar o = 0; o < `NumPorts; o++) begin : genOut
      if (i != o) begin : genLane
        localparam int Slot = (i < o) ? i : i - 1;

        switchLane lane (
          .RxClk, .rstN,
          .inItem(parsedItem[i]), .inValid(parsedValid[i]), .fwdBit(fwdMask[i][o]),
          .outActive(portActive[o]),
          .rdEn(laneRdEn[o][Slot]), .infoPop(laneInfoPop[o][Slot]),
          .rdItem(laneItem[o][Slot]), .pktReady(laneReady[o][Slot]),
          .pktErr(laneErr[o][Slot])
        );
      end
    end
  end

endmodule

// ==== testbench/ethSwitchTb.sv ====
// Table-driven testbench. Received frames are matched to table entries by source MAC,
// so source MACs must be unique. txReady on port 0 toggles randomly, never low over 3 cycles
`include "ethSwitch_settings.svh"
`timescale 1ns/100ps

module ethSwitchTb import ethSwitchPkg::*; ();

  localparam int NumEntries = 14;
  localparam int EndIdle    = 8;           // Idle cycles that close a received frame
  localparam int BufLen     = 80;
  localparam int ErrByte    = 14;          // Frame byte sent with rxErr high
  localparam logic [3:0] BoardId = 4'h5;
  localparam macAddrT Bcast = `BroadcastMac;
  localparam macAddrT PsMac = {`CompanyId, `PsMacField, 4'h0, BoardId};
  localparam macAddrT RtMac = {`CompanyId, `RtMacField, 4'h0, BoardId};
  localparam macAddrT MacA  = 48'h02AA_0000_000A;   // Host learned on port 0
  localparam macAddrT MacB  = 48'h02BB_0000_000B;

  typedef struct {
    int       port;
    macAddrT  dest;
    macAddrT  src;
    int       payLen;
    bit       err;
    portMaskT active;                      // portActive while the entry runs
    portMaskT expMask;                     // Output ports that must see the frame
    int       group;                       // Same group means sent at once
  } frameEntryT;

  logic RxClk, rstN;
  logic [`NumPorts-1:0] rxValid, rxErr, txReady, portActive, txEn, txErr;
  logic [`NumPorts-1:0][7:0] rxD, txD;
  logic [3:0] boardId;

  frameEntryT frameTable [NumEntries];
  logic [7:0] frameBytes [NumEntries][`MaxFrameBytes];
  int frameLen [NumEntries];
  portMaskT rcvMask [NumEntries];          // Ports that delivered each entry
  int entryErrs [NumEntries] = '{default: 0};
  int grpFirst = 0;
  int grpLast = -1;
  int passCount = 0;
  int failCount = 0;
  int cycleLimit = 0;
  int cycleCount = 0;
  int lowRun = 0;

  // Per-port collector state
  logic [7:0] rcvBuf [`NumPorts][BufLen];
  logic rcvErrFlag [`NumPorts][BufLen];
  int rcvCnt [`NumPorts] = '{default: 0};
  int idleCnt [`NumPorts] = '{default: 0};
  bit portSeen [`NumPorts] = '{default: 1'b0};

  ethSwitch dut (
    .RxClk, .rstN, .rxValid, .rxD, .rxErr, .txReady, .portActive, .boardId,
    .txEn, .txD, .txErr
  );

  initial begin
    RxClk = 1'b0;
    forever #10 RxClk = ~RxClk;
  end

  task automatic checkByte(input int e, input string sig, input byteItemT exp,
                           input byteItemT got);
    if (got === exp) begin
      passCount++;
    end else begin
      failCount++;
      entryErrs[e]++;
      $display("Error: %s expected %h got %h", sig, exp, got);
    end
  endtask

  task automatic checkMask(input int e, input string sig, input portMaskT exp,
                           input portMaskT got);
    if (got === exp) begin
      passCount++;
    end else begin
      failCount++;
      entryErrs[e]++;
      $display("Error: %s expected %h got %h", sig, exp, got);
    end
  endtask

  task automatic checkErr(input int e, input string sig, input infoItemT exp,
                          input infoItemT got);
    if (got === exp) begin
      passCount++;
    end else begin
      failCount++;
      entryErrs[e]++;
      $display("Error: %s expected %h got %h", sig, exp, got);
    end
  endtask

  task automatic noteFailure(input int e, input string msg);
    failCount++;
    if (e >= 0)
      entryErrs[e]++;
    $display("%s", msg);
  endtask

  task automatic loadTable();
    frameTable[0]  = '{2, Bcast, 48'h0200_0000_0002, 30, 1'b0, 4'b1111, 4'b1011, 0};
    frameTable[1]  = '{1, RtMac, 48'h0200_0000_0011, 20, 1'b0, 4'b1111, 4'b1000, 1};
    frameTable[2]  = '{3, 48'h0211_2233_4455, 48'h0200_0000_0023, 16, 1'b0,
                       4'b1111, 4'b0011, 2};                      // Unknown unicast
    frameTable[3]  = '{0, PsMac, MacA, 24, 1'b0, 4'b1111, 4'b0100, 3};   // Port 0 learns A
    frameTable[4]  = '{2, MacA, 48'h0200_0000_0042, 18, 1'b0, 4'b1111, 4'b0001, 4};
    frameTable[5]  = '{3, Bcast, 48'h0200_0000_0053, 22, 1'b0, 4'b1110, 4'b0110, 5};
    frameTable[6]  = '{2, MacA, 48'h0200_0000_0062, 26, 1'b0, 4'b1111, 4'b0011, 6};
    frameTable[7]  = '{3, Bcast, 48'h0200_0000_0073, 40, 1'b1, 4'b1111, 4'b0111, 7};
    frameTable[8]  = '{0, 48'h0233_4455_6677, MacB, 12, 1'b0, 4'b1111, 4'b0010, 8};
    frameTable[9]  = '{1, MacB, 48'h0200_0000_0091, 46, 1'b0, 4'b1111, 4'b0001, 9};
    frameTable[10] = '{2, MacB, 48'h0200_0000_00A2, 30, 1'b1, 4'b1111, 4'b0001, 9};
    frameTable[11] = '{3, MacB, 48'h0200_0000_00B3, 20, 1'b0, 4'b1111, 4'b0001, 9};
    frameTable[12] = '{2, Bcast, 48'h0200_0000_00C2, 28, 1'b0, 4'b1101, 4'b1001, 10};
    frameTable[13] = '{0, Bcast, 48'h0200_0000_00D0, 32, 1'b0, 4'b1111, 4'b1110, 11};
  endtask

  // Dest and source MSB byte first, then random payload
  task automatic buildFrame(input int e);
    for (int b = 0; b < 6; b++) begin
      frameBytes[e][b]     = frameTable[e].dest[47-8*b -: 8];
      frameBytes[e][6 + b] = frameTable[e].src[47-8*b -: 8];
    end
    for (int b = 0; b < frameTable[e].payLen; b++)
      frameBytes[e][12 + b] = 8'($urandom);
    frameLen[e] = 12 + frameTable[e].payLen;
  endtask

  // Stream position k: 7 preamble bytes, SFD, then the frame
  task automatic driveStreamByte(input int e, input int k);
    int p;
    p = frameTable[e].port;
    rxErr[p] = 1'b0;
    if (k < 7) begin
      rxValid[p] = 1'b1;
      rxD[p]     = 8'h55;
    end else if (k == 7) begin
      rxValid[p] = 1'b1;
      rxD[p]     = `SfdByte;
    end else if (k < frameLen[e] + 8) begin
      rxValid[p] = 1'b1;
      rxD[p]     = frameBytes[e][k - 8];
      rxErr[p]   = frameTable[e].err && (k == 8 + ErrByte);
    end else begin
      rxValid[p] = 1'b0;
      rxD[p]     = 8'h00;
    end
  endtask

  task automatic runGroup(input int first, input int last);
    int maxLen;
    bit done;
    for (int e = first; e <= last; e++) begin
      buildFrame(e);
      rcvMask[e] = '0;
    end
    grpFirst = first;
    grpLast  = last;
    @(posedge RxClk);
    #2;
    portActive = frameTable[first].active;
    repeat (4) @(posedge RxClk);
    maxLen = 0;
    for (int e = first; e <= last; e++)
      if (frameLen[e] + 8 > maxLen)
        maxLen = frameLen[e] + 8;
    for (int k = 0; k <= maxLen; k++) begin   // All ports of the group in lockstep
      @(posedge RxClk);
      #2;
      for (int e = first; e <= last; e++)
        driveStreamByte(e, k);
    end
    done = 1'b0;
    while (!done) begin                        // Every expected copy delivered
      @(posedge RxClk);
      done = 1'b1;
      for (int e = first; e <= last; e++)
        if ((rcvMask[e] & frameTable[e].expMask) != frameTable[e].expMask)
          done = 1'b0;
    end
    repeat (60) @(posedge RxClk);            // Let stray copies show up
    for (int e = first; e <= last; e++) begin
      checkMask(e, $sformatf("txEn ports for entry %0d", e), frameTable[e].expMask,
                rcvMask[e]);
      $display("Entry %0d from port %0d to ports %b: %s", e, frameTable[e].port,
               frameTable[e].expMask, (entryErrs[e] == 0) ? "ok" : "FAILED");
    end
  endtask

  task automatic closeFrame(input int p);
    int n, found, lastIdx;
    macAddrT src;
    byteItemT expItem, gotItem;
    n = rcvCnt[p];
    found = -1;
    lastIdx = (n < BufLen) ? n - 1 : BufLen - 1;
    if (n >= 12) begin
      for (int b = 0; b < 6; b++)
        src[47-8*b -: 8] = rcvBuf[p][6 + b];
      for (int e = grpFirst; e <= grpLast; e++)
        if (frameTable[e].src == src)
          found = e;
    end
    if (found < 0) begin
      noteFailure(-1, $sformatf("Unexpected frame of %0d bytes on port %0d", n, p));
      return;
    end
    if (rcvMask[found][p])
      noteFailure(found, $sformatf("Entry %0d arrived twice on port %0d", found, p));
    rcvMask[found][p] = 1'b1;
    if (n != frameLen[found])
      noteFailure(found, $sformatf("Entry %0d on port %0d has %0d bytes, %0d were sent",
                                   found, p, n, frameLen[found]));
    for (int b = 0; b <= lastIdx && b < frameLen[found]; b++) begin
      expItem.data = frameBytes[found][b];
      if (b == 0)
        expItem.stat = statFirst;
      else if (b == frameLen[found] - 1)
        expItem.stat = frameTable[found].err ? statErr : statLast;
      else
        expItem.stat = statNone;
      gotItem.data = rcvBuf[p][b];
      if (rcvErrFlag[p][b])
        gotItem.stat = statErr;              // txErr seen on this byte
      else if (b == 0)
        gotItem.stat = statFirst;
      else if (b == n - 1)
        gotItem.stat = statLast;
      else
        gotItem.stat = statNone;
      checkByte(found, $sformatf("txD[%0d] byte %0d", p, b), expItem, gotItem);
    end
    checkErr(found, $sformatf("txErr[%0d] on last byte", p), infoItemT'(frameTable[found].err),
             infoItemT'(rcvErrFlag[p][lastIdx]));
  endtask

  // Collectors sample mid-cycle, away from the edges
  always @(negedge RxClk) begin
    for (int p = 0; p < `NumPorts; p++) begin
      if (txEn[p] === 1'b1) begin
        if (rcvCnt[p] == 0 && portSeen[p] && idleCnt[p] < `InterPacketGap)
          noteFailure(-1, $sformatf("Only %0d idle cycles before a frame on port %0d",
                                    idleCnt[p], p));
        if (rcvCnt[p] < BufLen) begin
          rcvBuf[p][rcvCnt[p]]     = txD[p];
          rcvErrFlag[p][rcvCnt[p]] = txErr[p];
        end
        rcvCnt[p]++;
        idleCnt[p] = 0;
      end else begin
        idleCnt[p]++;
        if (rcvCnt[p] > 0 && idleCnt[p] == EndIdle) begin
          closeFrame(p);
          rcvCnt[p]   = 0;
          portSeen[p] = 1'b1;
        end
      end
    end
  end

  // Random back-pressure on port 0
  initial begin
    wait (rstN === 1'b1);
    forever begin
      @(posedge RxClk);
      #2;
      if (lowRun < 3 && ($urandom & 32'd1) == 32'd0) begin
        txReady[0] = 1'b0;
        lowRun++;
      end else begin
        txReady[0] = 1'b1;
        lowRun = 0;
      end
    end
  end

  initial begin
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge RxClk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int first, last, limit;
    void'($urandom(32'h96d2));
    rstN       = 1'b0;
    rxValid    = '0;
    rxD        = '0;
    rxErr      = '0;
    txReady    = '1;
    portActive = '1;
    boardId    = BoardId;
    loadTable();
    limit = 0;
    for (int e = 0; e < NumEntries; e++)
      limit += (frameTable[e].payLen + 20) * 4 + 200;   // Preamble, SFD and header included
    cycleLimit = limit;
    repeat (5) @(posedge RxClk);
    #2;
    rstN = 1'b1;
    repeat (5) @(posedge RxClk);
    first = 0;
    while (first < NumEntries) begin
      last = first;
      while (last + 1 < NumEntries && frameTable[last + 1].group == frameTable[first].group)
        last++;
      runGroup(first, last);
      first = last + 1;
    end
    $display("Summary: %0d checks passed, %0d failures", passCount, failCount);
    if (failCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== ethSwitch.f ====
+incdir+include
source/ethSwitchPkg.sv
source/rxFrameParser.sv
source/forwardDecision.sv
source/packetQueue.sv
source/switchLane.sv
source/txScheduler.sv
source/ethSwitch.sv
testbench/ethSwitchTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module ethSwitchTb \
  -f ethSwitch.f -o simEthSwitch

simStatus=0
./obj_dir/simEthSwitch > sim.log 2>&1 || simStatus=$?
cat sim.log

if [ "$simStatus" -eq 0 ] && grep -qx "Simulation passed" sim.log; then
  exit 0
fi
exit 1
